// File: project.f
+incdir+include
logic/unpack_data_pkg.sv
logic/unpack_ctrl_pkg.sv
logic/word_fifo.sv
logic/bit_fifo.sv
logic/unpack_ctrl.sv
logic/unpack_top.sv
verification/tb_unpack.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the unpacker testbench with Verilator and runs it.
# Exits non-zero unless the pass message shows up in the output.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter the project directory"
   exit 1
fi

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_unpack -o tb_unpack_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_output="$(./obj_dir/tb_unpack_sim)"
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_output" | grep -q "Test completed successfully"; then
   exit 0
fi
echo "pass message not found in the simulation output"
exit 1

// File: verification/tb_unpack.sv
`include "unpack_settings.svh"

module tb_unpack
   import unpack_data_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int DATA_W = `UNPACK_DATA_W;

   // words per test
   localparam int N_CONT       = 30;
   localparam int N_FULL       = 12;
   localparam int N_WRAP       = 12;
   localparam int N_BACK       = 24;
   localparam int N_RAND_SEG   = 8;
   localparam int N_RAND_WORDS = 6;
   localparam int TOTAL_WORDS  = N_CONT + N_FULL + N_WRAP + N_BACK
                                 + N_RAND_SEG * N_RAND_WORDS;
   localparam int CYCLE_LIMIT  = 40 * TOTAL_WORDS + 200;

   // output empty this long means the segment has ended
   localparam int IDLE_LIMIT   = 4 * DATA_W;

   typedef packed_word_t word_q_t[$];
   typedef field_word_t  field_q_t[$];

   logic         clk;
   logic         rst_n;
   logic         wrap_sel;
   field_width_t field_width;
   logic         in_write;
   packed_word_t in_data;
   logic         in_full;
   logic         out_read;
   field_word_t  out_data;
   logic         out_empty;

   logic [31:0]  lfsr_state;
   word_q_t      seg_words;
   field_q_t     exp_q;
   field_word_t  exp_field;
   int           seg_expected;
   int           received;
   int           total_checked;
   int           error_count;
   int           cycle_count;
   logic         read_seen;

   unpack_top i_dut (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .wrap_i     (wrap_sel),
      .width_i    (field_width),
      .in_write_i (in_write),
      .in_data_i  (in_data),
      .in_full_o  (in_full),
      .out_read_i (out_read),
      .out_data_o (out_data),
      .out_empty_o(out_empty)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic feedback;
      feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], feedback};
   endfunction

   function automatic logic [31:0] random_bits(input int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   // expected fields, built bit by bit from the oldest bit on
   function automatic field_q_t expected_fields(input word_q_t words, input int width,
                                                input bit wrap_mode);
      field_q_t    fields;
      bit          stream[$];
      field_word_t field;
      int          per_word;
      if (wrap_mode) begin
         // whole fields from the top of each word, low leftovers dropped
         per_word = DATA_W / width;
         foreach (words[w]) begin
            for (int f = 0; f < per_word; f++) begin
               field = '0;
               for (int k = 0; k < width; k++) begin
                  field = {field[DATA_W-2:0], words[w][DATA_W-1-f*width-k]};
               end
               fields.push_back(field);
            end
         end
      end else begin
         foreach (words[w]) begin
            for (int i = DATA_W - 1; i >= 0; i--) begin
               stream.push_back(words[w][i]);
            end
         end
         // incomplete tail stays behind
         while (stream.size() >= width) begin
            field = '0;
            for (int k = 0; k < width; k++) begin
               field = {field[DATA_W-2:0], stream.pop_front()};
            end
            fields.push_back(field);
         end
      end
      return fields;
   endfunction

   task automatic check_field(input field_word_t got, input field_word_t expected,
                              input int index);
      if (got !== expected) begin
         $display("CHECK FAILED out_data_o field %0d: got 0x%h, expected 0x%h",
                  index, got, expected);
         error_count++;
      end
   endtask

   task automatic check_flag(input logic got, input logic expected, input string name);
      if (got !== expected) begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
         error_count++;
      end
   endtask

   task automatic check_count(input int expected, input int got);
      if (got != expected) begin
         $display("%0d fields were read from the output, %0d were expected", got, expected);
         error_count++;
      end
   endtask

   task automatic apply_reset(input bit wrap_mode, input int width);
      @(negedge clk);
      rst_n       = 1'b0;
      in_write    = 1'b0;
      out_read    = 1'b0;
      wrap_sel    = wrap_mode;
      field_width = field_width_t'(width);
      repeat (2) @(negedge clk);
      // both fifos come out of reset empty
      check_flag(in_full, 1'b0, "in_full_o");
      check_flag(out_empty, 1'b1, "out_empty_o");
      received = 0;
      rst_n    = 1'b1;
   endtask

   // one word per falling edge while the input fifo has room
   task automatic write_words();
      int idx;
      idx = 0;
      while (idx < seg_words.size()) begin
         @(negedge clk);
         if (!in_full) begin
            in_write = 1'b1;
            in_data  = seg_words[idx];
            idx++;
         end else begin
            in_write = 1'b0;
         end
      end
      @(negedge clk);
      in_write = 1'b0;
   endtask

   // reads every field that shows up, extra ones included
   task automatic read_fields(input bit hold_reads);
      int idle;
      idle = 0;
      if (hold_reads) begin
         // let the whole chain back up first
         while (!in_full) begin
            @(negedge clk);
         end
      end
      while (idle < IDLE_LIMIT) begin
         @(negedge clk);
         if (!out_empty) begin
            out_read = 1'b1;
            idle     = 0;
         end else begin
            out_read = 1'b0;
            idle++;
         end
      end
   endtask

   task automatic run_segment(input bit wrap_mode, input int width, input int n_words,
                              input bit hold_reads);
      seg_words.delete();
      for (int i = 0; i < n_words; i++) begin
         seg_words.push_back(packed_word_t'(random_bits(DATA_W)));
      end
      exp_q        = expected_fields(seg_words, width, wrap_mode);
      seg_expected = exp_q.size();
      apply_reset(wrap_mode, width);
      fork
         write_words();
         read_fields(hold_reads);
      join
      check_count(seg_expected, received);
   endtask

   // a read strobe seen at the rising edge means data to check next falling edge
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_seen <= 1'b0;
      end else begin
         read_seen <= out_read;
      end
   end

   always @(negedge clk) begin
      if (read_seen) begin
         if (exp_q.size() == 0) begin
            $display("a field 0x%h was read although none was expected", out_data);
            error_count++;
         end else begin
            exp_field = exp_q.pop_front();
            check_field(out_data, exp_field, received);
            total_checked++;
         end
         received++;
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("errors: %0d, fields checked: %0d", error_count, total_checked);
      $display("Test failed");
      $finish;
   end

   initial begin
      int rand_width;
      rst_n         = 1'b0;
      wrap_sel      = 1'b0;
      field_width   = field_width_t'(5);
      in_write      = 1'b0;
      in_data       = '0;
      out_read      = 1'b0;
      lfsr_state    = 32'h6c83;
      received      = 0;
      total_checked = 0;
      error_count   = 0;
      seg_expected  = 0;

      // straddling fields
      run_segment(1'b0, 5, N_CONT, 1'b0);
      // output words are the input words
      run_segment(1'b0, DATA_W, N_FULL, 1'b0);
      // five fields per word, lsb dropped
      run_segment(1'b1, 4, N_WRAP, 1'b0);
      // output held back until the input fifo is full
      run_segment(1'b0, 7, N_BACK, 1'b1);

      for (int s = 0; s < N_RAND_SEG; s++) begin
         rand_width = int'(random_bits(5) % DATA_W) + 1;
         run_segment((s % 2) == 1, rand_width, N_RAND_WORDS, 1'b0);
      end

      $display("errors: %0d, fields checked: %0d", error_count, total_checked);
      if (error_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: logic/unpack_top.sv
`include "unpack_settings.svh"

module unpack_top
   import unpack_data_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  logic         wrap_i,
   input  field_width_t width_i,

   // packed word input
   input  logic         in_write_i,
   input  packed_word_t in_data_i,
   output logic         in_full_o,

   // unpacked field output
   input  logic         out_read_i,
   output field_word_t  out_data_o,
   output logic         out_empty_o
);

   logic         in_read;
   logic         in_empty;
   packed_word_t in_rdata;

   logic         out_write;
   logic         out_full;
   field_word_t  out_wdata;

   word_fifo #(
      .payload_t(packed_word_t),
      .DEPTH    (`UNPACK_FIFO_DEPTH)
   ) i_in_fifo (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .write_i(in_write_i),
      .wdata_i(in_data_i),
      .full_o (in_full_o),
      .read_i (in_read),
      .rdata_o(in_rdata),
      .empty_o(in_empty)
   );

   unpack_ctrl i_ctrl (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .wrap_i  (wrap_i),
      .width_i (width_i),
      .read_o  (in_read),
      .rready_i(!in_empty),
      .rdata_i (in_rdata),
      .write_o (out_write),
      .wready_i(!out_full),
      .wdata_o (out_wdata)
   );

   // fields wait here until the environment reads them
   word_fifo #(
      .payload_t(field_word_t),
      .DEPTH    (`UNPACK_FIFO_DEPTH)
   ) i_out_fifo (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .write_i(out_write),
      .wdata_i(out_wdata),
      .full_o (out_full),
      .read_i (out_read_i),
      .rdata_o(out_data_o),
      .empty_o(out_empty_o)
   );

endmodule

// File: logic/unpack_ctrl.sv
`include "unpack_settings.svh"

module unpack_ctrl
   import unpack_data_pkg::*;
   import unpack_ctrl_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  logic         wrap_i,
   input  field_width_t width_i,

   // packed words from the input fifo
   output logic         read_o,
   input  logic         rready_i,
   input  packed_word_t rdata_i,

   // unpacked fields to the output fifo
   output logic         write_o,
   input  logic         wready_i,
   output field_word_t  wdata_o
);

   unpack_step_t pcnt;
   unpack_step_t pcnt_nxt;

   // wrap mode push width, sum of whole fields per word
   field_width_t wrap_acc;
   field_width_t wrap_acc_nxt;
   logic [`UNPACK_WIDTH_W:0] wrap_acc_sum;

   field_width_t push_width;
   logic         push;
   logic         pop;
   bit_level_t   push_level;
   bit_level_t   pop_level;

   assign push_width   = wrap_i ? wrap_acc : field_width_t'(`UNPACK_DATA_W);
   assign wrap_acc_sum = {1'b0, wrap_acc} + {1'b0, width_i};
   assign write_o      = pop;

   always_comb begin
      read_o       = 1'b0;
      push         = 1'b0;
      pop          = 1'b0;
      wrap_acc_nxt = wrap_acc;
      pcnt_nxt     = pcnt;

      case (pcnt)
         calc_push_width: begin
            // keep adding fields while they fit in one word
            if (wrap_i && (wrap_acc_sum <= (`UNPACK_WIDTH_W + 1)'(`UNPACK_DATA_W))) begin
               wrap_acc_nxt = wrap_acc_sum[`UNPACK_WIDTH_W-1:0];
            end else begin
               pcnt_nxt = wait_data;
            end
         end
         wait_data: begin
            // need a word and room for the push
            if (rready_i && (push_level >= bit_level_t'(push_width))) begin
               read_o   = 1'b1;
               pcnt_nxt = push_data;
            end else begin
               pcnt_nxt = pop_data;
            end
         end
         push_data: begin
            // input fifo data is valid now
            push     = 1'b1;
            pcnt_nxt = pop_data;
         end
         default: begin
            if ((pop_level >= bit_level_t'(width_i)) && wready_i) begin
               pop = 1'b1;
            end
            pcnt_nxt = wait_data;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pcnt     <= calc_push_width;
         wrap_acc <= '0;
      end else begin
         pcnt     <= pcnt_nxt;
         wrap_acc <= wrap_acc_nxt;
      end
   end

   bit_fifo i_bit_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .write_i (push),
      .wwidth_i(push_width),
      .wdata_i (rdata_i),
      .wlevel_o(push_level),
      .read_i  (pop),
      .rwidth_i(width_i),
      .rdata_o (wdata_o),
      .rlevel_o(pop_level)
   );

endmodule

// File: logic/bit_fifo.sv
`include "unpack_settings.svh"

module bit_fifo
   import unpack_data_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_n_i,

   // push side, takes the top wwidth_i bits of wdata_i
   input  logic         write_i,
   input  field_width_t wwidth_i,
   input  packed_word_t wdata_i,
   output bit_level_t   wlevel_o,

   // pop side, oldest rwidth_i bits right-aligned
   input  logic         read_i,
   input  field_width_t rwidth_i,
   output field_word_t  rdata_o,
   output bit_level_t   rlevel_o
);

   localparam int DATA_W = `UNPACK_DATA_W;
   localparam int BUF_W  = 2 * DATA_W;

   // held bits sit at the top of the buffer, oldest in the msb
   logic [BUF_W-1:0] buffer;
   bit_level_t       level;

   logic [BUF_W-1:0] buffer_popped;
   bit_level_t       level_popped;
   logic [BUF_W-1:0] keep_mask;

   packed_word_t     push_mask;
   packed_word_t     push_bits;
   logic [BUF_W-1:0] push_aligned;

   logic [BUF_W-1:0] buffer_nxt;
   bit_level_t       level_nxt;
   logic [BUF_W-1:0] head_shifted;

   assign rlevel_o = level;
   assign wlevel_o = bit_level_t'(BUF_W) - level;

   // head bits shifted down to the lsb end
   assign head_shifted = buffer >> (BUF_W - int'(rwidth_i));
   assign rdata_o      = head_shifted[DATA_W-1:0];

   always_comb begin
      // pop first so a push in the same cycle lands after the rest
      if (read_i) begin
         buffer_popped = buffer << rwidth_i;
         level_popped  = level - bit_level_t'(rwidth_i);
      end else begin
         buffer_popped = buffer;
         level_popped  = level;
      end

      // clear everything below the held bits
      keep_mask = ~({BUF_W{1'b1}} >> level_popped);

      // top wwidth_i bits of the word, rest zero
      push_mask    = ~({DATA_W{1'b1}} >> wwidth_i);
      push_bits    = wdata_i & push_mask;
      push_aligned = {push_bits, {DATA_W{1'b0}}} >> level_popped;

      if (write_i) begin
         buffer_nxt = (buffer_popped & keep_mask) | push_aligned;
         level_nxt  = level_popped + bit_level_t'(wwidth_i);
      end else begin
         buffer_nxt = buffer_popped & keep_mask;
         level_nxt  = level_popped;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         level <= '0;
      end else begin
         level <= level_nxt;
      end
   end

   // bit storage, only the level decides what is valid
   always_ff @(posedge clk_i) begin
      buffer <= buffer_nxt;
   end

endmodule

// File: logic/word_fifo.sv
module word_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 8
) (
   input  logic     clk_i,
   input  logic     rst_n_i,

   input  logic     write_i,
   input  payload_t wdata_i,
   output logic     full_o,

   input  logic     read_i,
   output payload_t rdata_o,
   output logic     empty_o
);

   // pointers need at least one bit even for a single entry
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t   mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   logic do_write;
   logic do_read;

   assign full_o  = (count == CNT_W'(DEPTH));
   assign empty_o = (count == '0);

   // strobes against a full or empty buffer are ignored
   assign do_write = write_i && !full_o;
   assign do_read  = read_i && !empty_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            // wrap explicitly so any depth works
            if (wr_ptr == PTR_W'(DEPTH - 1)) begin
               wr_ptr <= '0;
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (do_read) begin
            if (rd_ptr == PTR_W'(DEPTH - 1)) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         if (do_write && !do_read) begin
            count <= count + 1'b1;
         end else if (do_read && !do_write) begin
            count <= count - 1'b1;
         end
      end
   end

   // storage and registered read data
   always_ff @(posedge clk_i) begin
      if (do_write) begin
         mem[wr_ptr] <= wdata_i;
      end
      if (do_read) begin
         rdata_o <= mem[rd_ptr];
      end
   end

endmodule

// File: logic/unpack_ctrl_pkg.sv
package unpack_ctrl_pkg;

   // program counter of the unpack controller
   // calc_push_width runs only after reset, then the loop is
   // wait_data -> push_data -> pop_data -> wait_data
   typedef enum logic [1:0] {
      calc_push_width = 2'd0,
      wait_data       = 2'd1,
      push_data       = 2'd2,
      pop_data        = 2'd3
   } unpack_step_t;

endpackage

// File: logic/unpack_data_pkg.sv
`include "unpack_settings.svh"

package unpack_data_pkg;

   // packed input word, oldest bit in the msb
   typedef logic [`UNPACK_DATA_W-1:0] packed_word_t;

   // unpacked field, right-aligned, zeros above its width
   typedef logic [`UNPACK_DATA_W-1:0] field_word_t;

   // field width or push width in bits
   typedef logic [`UNPACK_WIDTH_W-1:0] field_width_t;

   // number of bits held in (or free in) the bit fifo
   typedef logic [`UNPACK_LEVEL_W-1:0] bit_level_t;

endpackage

// File: include/unpack_settings.svh
`ifndef UNPACK_SETTINGS_SVH
`define UNPACK_SETTINGS_SVH

// width of the packed word bus and of each output word
`define UNPACK_DATA_W 21

// field width counts 1 to UNPACK_DATA_W
`define UNPACK_WIDTH_W ($clog2(`UNPACK_DATA_W) + 1)

// bit fifo holds up to two words
`define UNPACK_LEVEL_W ($clog2(2 * `UNPACK_DATA_W) + 1)

// entries in each word fifo
`define UNPACK_FIFO_DEPTH 8

`endif
